// File: hdl/rxlink_map_pkg.sv
package rxlink_map_pkg;

    ////////////////////
    // bus widths
    ////////////////////
    localparam int ADR_BITS = 11;
    localparam int DAT_BITS = 32;
    localparam int SEL_BITS = 4;

    ////////////////////
    // address map
    ////////////////////
    // bits 7:6 pick the clock domain
    localparam logic [ADR_BITS-1:0] DOMAIN_MASK  = 11'h0C0;
    localparam logic [ADR_BITS-1:0] RXCLK_DOMAIN = 11'h080;
    // offset inside a domain window
    localparam logic [ADR_BITS-1:0] REG_MASK     = 11'h03F;
    localparam logic [ADR_BITS-1:0] CONTROL_REG  = 11'h000;

    // taps at 0x80/0x84/0x88/0x8C select on adr[3:2]
    localparam int DELAY_SEL_LSB = 2;
    localparam int DELAY_BITS    = 9;

endpackage

// File: hdl/rxlink_ctrl_pkg.sv
package rxlink_ctrl_pkg;

    // rxclk multiplier 12 times 56 fine steps per vco period
    localparam int PS_STEPS = 672;
    localparam int PS_BITS  = 10;

    ////////////////////
    // control word
    ////////////////////
    typedef struct packed {
        logic               ps_incomplete;   // 31
        logic [4:0]         reserved_hi;     // 30:26
        logic [PS_BITS-1:0] ps_target;       // 25:16
        logic [7:0]         reserved_lo;     // 15:8
        logic               data_active;     // 7
        logic               train_en;        // 6
        logic               mmcm_locked;     // 5
        logic               mmcm_rst;        // 4
        logic               idelayctrl_rdy;  // 3
        logic               idelayctrl_rst;  // 2
        logic               dis_vtc;         // 1
        logic               cin_rst;         // 0
    } ctrl_fields_t;

    // raw view for the bus, field view for the outputs
    typedef union packed {
        ctrl_fields_t f;
        logic [31:0]  raw;
    } ctrl_word_u;

endpackage

// File: hdl/delay_req_if.sv
interface delay_req_if;
    import rxlink_map_pkg::*;

    // level, high while the bus FSM waits on rxclk
    logic                  req;
    logic                  we;
    logic [1:0]            sel_lo;
    logic [1:0]            tap;
    logic [DELAY_BITS-1:0] wdata;
    // single wbclk pulse back from the bridge
    logic                  ack;
    logic [DELAY_BITS-1:0] rdata;

    modport fsm (
        output req, we, sel_lo, tap, wdata,
        input  ack, rdata
    );

    modport bridge (
        input  req, we, sel_lo, tap, wdata,
        output ack, rdata
    );

endinterface

// File: hdl/flag_sync.sv
module flag_sync (
    input  logic clk_a_i,
    input  logic rst_a_i,
    input  logic pulse_a_i,
    input  logic clk_b_i,
    input  logic rst_b_i,
    output logic pulse_b_o
);

    logic       toggle_a;
    logic [2:0] shift_b;

    // source side flips once per pulse
    always_ff @(posedge clk_a_i) begin
        if (rst_a_i) begin
            toggle_a <= 1'b0;
        end else if (pulse_a_i) begin
            toggle_a <= ~toggle_a;
        end
    end

    // first two stages resolve metastability
    always_ff @(posedge clk_b_i) begin
        if (rst_b_i) begin
            shift_b <= 3'b000;
        end else begin
            shift_b <= {shift_b[1:0], toggle_a};
        end
    end

    assign pulse_b_o = shift_b[2] ^ shift_b[1];

endmodule

// File: hdl/ctrl_reg_file.sv
module ctrl_reg_file (
    input  logic                                  wb_clk_i,
    input  logic                                  wb_rst_i,
    input  logic                                  ctrl_wr_i,
    input  logic [rxlink_map_pkg::DAT_BITS-1:0]   wr_data_i,
    input  logic [rxlink_map_pkg::SEL_BITS-1:0]   wr_sel_i,
    input  logic                                  ps_incomplete_i,
    input  logic                                  idelayctrl_rdy_i,
    input  logic                                  mmcm_locked_i,
    input  logic                                  data_active_i,
    output rxlink_ctrl_pkg::ctrl_word_u           ctrl_word_o,
    output logic [rxlink_ctrl_pkg::PS_BITS-1:0]   ps_target_o,
    output logic                                  cin_rst_o,
    output logic                                  en_vtc_o,
    output logic                                  idelayctrl_rst_o,
    output logic                                  mmcm_rst_o,
    output logic                                  train_en_o
);
    import rxlink_ctrl_pkg::*;

    ctrl_word_u wr_word;
    ctrl_word_u ctrl_q;
    // {data_active, mmcm_locked, idelayctrl_rdy}
    logic [2:0] stat_meta;
    logic [2:0] stat_sync;

    assign wr_word.raw = wr_data_i;

    ////////////////////
    // writable bits
    ////////////////////
    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            ctrl_q.raw <= '0;
        end else if (ctrl_wr_i) begin
            if (wr_sel_i[0]) begin
                ctrl_q.f.cin_rst        <= wr_word.f.cin_rst;
                ctrl_q.f.dis_vtc        <= wr_word.f.dis_vtc;
                ctrl_q.f.idelayctrl_rst <= wr_word.f.idelayctrl_rst;
                ctrl_q.f.mmcm_rst       <= wr_word.f.mmcm_rst;
                ctrl_q.f.train_en       <= wr_word.f.train_en;
            end
            // target straddles bytes 2 and 3
            if (wr_sel_i[2] && wr_sel_i[3]) begin
                ctrl_q.f.ps_target <= wr_word.f.ps_target;
            end
        end
    end

    // status levels into wbclk
    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            stat_meta <= 3'b000;
            stat_sync <= 3'b000;
        end else begin
            stat_meta <= {data_active_i, mmcm_locked_i, idelayctrl_rdy_i};
            stat_sync <= stat_meta;
        end
    end

    // status and reserved bits never get written, so they start from zero
    always_comb begin
        ctrl_word_o                  = ctrl_q;
        ctrl_word_o.f.idelayctrl_rdy = stat_sync[0];
        ctrl_word_o.f.mmcm_locked    = stat_sync[1];
        ctrl_word_o.f.data_active    = stat_sync[2];
        ctrl_word_o.f.ps_incomplete  = ps_incomplete_i;
    end

    assign ps_target_o      = ctrl_q.f.ps_target;
    assign cin_rst_o        = ctrl_q.f.cin_rst;
    assign en_vtc_o         = ~ctrl_q.f.dis_vtc;
    assign idelayctrl_rst_o = ctrl_q.f.idelayctrl_rst;
    assign mmcm_rst_o       = ctrl_q.f.mmcm_rst;
    assign train_en_o       = ctrl_q.f.train_en;

endmodule

// File: hdl/phase_shift_stepper.sv
module phase_shift_stepper (
    input  logic                                wb_clk_i,
    input  logic                                wb_rst_i,
    input  logic [rxlink_ctrl_pkg::PS_BITS-1:0] ps_target_i,
    input  logic                                ps_done_i,
    output logic                                ps_en_o,
    output logic                                ps_incomplete_o
);
    import rxlink_ctrl_pkg::*;

    logic [PS_BITS-1:0] cur_q;
    // a step was issued and ps_done has not come back
    logic               busy_q;
    logic               at_target;

    assign at_target = (cur_q == ps_target_i);

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            cur_q   <= '0;
            busy_q  <= 1'b0;
            ps_en_o <= 1'b0;
        end else begin
            ps_en_o <= !at_target && !busy_q && !ps_en_o;
            if (ps_en_o) begin
                busy_q <= 1'b1;
            end else if (ps_done_i) begin
                busy_q <= 1'b0;
            end
            // position wraps around one full vco turn
            if (ps_en_o) begin
                if (cur_q == PS_BITS'(PS_STEPS - 1)) begin
                    cur_q <= '0;
                end else begin
                    cur_q <= cur_q + 1'b1;
                end
            end
        end
    end

    assign ps_incomplete_o = !at_target || busy_q || ps_en_o;

    // next step no sooner than two cycles after ps_done
    step_outstanding: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
        ps_done_i |=> !ps_en_o);

endmodule

// File: hdl/rxclk_delay_bridge.sv
module rxclk_delay_bridge (
    input  logic                                   wb_clk_i,
    input  logic                                   wb_rst_i,
    input  logic                                   rxclk_i,
    input  logic [rxlink_map_pkg::DELAY_BITS-1:0]  delay_cntvalueout_i,
    delay_req_if.bridge                            dly,
    output logic                                   delay_load_o,
    output logic                                   delay_rd_o,
    output logic [1:0]                             delay_sel_o,
    output logic [rxlink_map_pkg::DELAY_BITS-1:0]  delay_cntvaluein_o
);

    logic       req_q;
    logic       req_rise;
    logic [1:0] rst_rx_q;
    logic       go_rx;
    logic       ack_rx;

    ////////////////////
    // wbclk side
    ////////////////////
    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            req_q <= 1'b0;
        end else begin
            req_q <= dly.req;
        end
    end

    assign req_rise = dly.req && !req_q;

    ////////////////////
    // rxclk side
    ////////////////////
    // bus reset carried over for the rxclk flops
    always_ff @(posedge rxclk_i) begin
        rst_rx_q <= {rst_rx_q[0], wb_rst_i};
    end

    flag_sync u_req_sync (
        .clk_a_i   (wb_clk_i),
        .rst_a_i   (wb_rst_i),
        .pulse_a_i (req_rise),
        .clk_b_i   (rxclk_i),
        .rst_b_i   (rst_rx_q[1]),
        .pulse_b_o (go_rx)
    );

    // one rxclk later so a read strobe has updated the tap value
    always_ff @(posedge rxclk_i) begin
        if (rst_rx_q[1]) begin
            ack_rx <= 1'b0;
        end else begin
            ack_rx <= go_rx;
        end
    end

    flag_sync u_ack_sync (
        .clk_a_i   (rxclk_i),
        .rst_a_i   (rst_rx_q[1]),
        .pulse_a_i (ack_rx),
        .clk_b_i   (wb_clk_i),
        .rst_b_i   (wb_rst_i),
        .pulse_b_o (dly.ack)
    );

    // request fields stay put while req is high
    assign delay_load_o       = go_rx && dly.we && (dly.sel_lo == 2'b11);
    assign delay_rd_o         = go_rx && !dly.we;
    assign delay_sel_o        = dly.tap;
    assign delay_cntvaluein_o = dly.wdata;
    assign dly.rdata          = delay_cntvalueout_i;

endmodule

// File: hdl/wb_access_ctrl.sv
module wb_access_ctrl (
    input  logic                                 wb_clk_i,
    input  logic                                 wb_rst_i,
    input  logic                                 wb_cyc_i,
    input  logic                                 wb_stb_i,
    input  logic                                 wb_we_i,
    input  logic [rxlink_map_pkg::ADR_BITS-1:0]  wb_adr_i,
    input  logic [rxlink_map_pkg::SEL_BITS-1:0]  wb_sel_i,
    input  logic [rxlink_map_pkg::DAT_BITS-1:0]  wb_dat_i,
    input  logic                                 rxclk_ok_i,
    input  rxlink_ctrl_pkg::ctrl_word_u          ctrl_word_i,
    output logic [rxlink_map_pkg::DAT_BITS-1:0]  wb_dat_o,
    output logic                                 wb_ack_o,
    output logic                                 ctrl_wr_o,
    output logic [rxlink_map_pkg::DAT_BITS-1:0]  wr_data_o,
    output logic [rxlink_map_pkg::SEL_BITS-1:0]  wr_sel_o,
    delay_req_if.fsm                             dly
);
    import rxlink_map_pkg::*;

    enum logic [1:0] {IDLE, ACK, WAIT_RXCLK} state_q;

    logic [ADR_BITS-1:0] adr_q;
    logic                we_q;
    logic [SEL_BITS-1:0] sel_q;
    logic [DAT_BITS-1:0] dat_q;
    logic [DAT_BITS-1:0] rdata_q;
    logic                strobe;
    logic                rxclk_access;
    logic                ctrl_hit;

    assign strobe       = wb_cyc_i && wb_stb_i;
    // checked against the live address in IDLE
    assign rxclk_access = (wb_adr_i & DOMAIN_MASK) == RXCLK_DOMAIN;
    // old aclk window falls through to the control word on reads only
    assign ctrl_hit     = (adr_q & (DOMAIN_MASK | REG_MASK)) == CONTROL_REG;

    ////////////////////
    // request capture
    ////////////////////
    always_ff @(posedge wb_clk_i) begin
        if (strobe) begin
            adr_q <= wb_adr_i;
            we_q  <= wb_we_i;
            sel_q <= wb_sel_i;
            dat_q <= wb_dat_i;
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (wb_rst_i) begin
            state_q <= IDLE;
        end else begin
            case (state_q)
                IDLE: begin
                    if (strobe) begin
                        state_q <= rxclk_access ? WAIT_RXCLK : ACK;
                    end
                end
                ACK: state_q <= IDLE;
                WAIT_RXCLK: begin
                    if (dly.ack || !rxclk_ok_i) begin
                        state_q <= ACK;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // read data mux
    always_ff @(posedge wb_clk_i) begin
        if (state_q == IDLE && strobe) begin
            rdata_q <= ctrl_word_i.raw;
        end else if (state_q == WAIT_RXCLK) begin
            if (dly.ack) begin
                rdata_q <= {{(DAT_BITS - DELAY_BITS){1'b0}}, dly.rdata};
            end else if (!rxclk_ok_i) begin
                rdata_q <= '1;
            end
        end
    end

    assign wb_ack_o  = (state_q == ACK);
    assign wb_dat_o  = rdata_q;
    assign ctrl_wr_o = (state_q == ACK) && we_q && ctrl_hit;
    assign wr_data_o = dat_q;
    assign wr_sel_o  = sel_q;

    assign dly.req    = (state_q == WAIT_RXCLK);
    assign dly.we     = we_q;
    assign dly.sel_lo = sel_q[1:0];
    assign dly.tap    = adr_q[DELAY_SEL_LSB +: 2];
    assign dly.wdata  = dat_q[DELAY_BITS-1:0];

    // an ack only answers a strobe still held by the master
    ack_after_strobe: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
        wb_ack_o |-> $past(strobe));

endmodule

// File: hdl/rxlink_reg_core.sv
module rxlink_reg_core (
    input  logic                                  wb_clk_i,
    input  logic                                  wb_rst_i,
    input  logic                                  wb_cyc_i,
    input  logic                                  wb_stb_i,
    input  logic                                  wb_we_i,
    input  logic [rxlink_map_pkg::ADR_BITS-1:0]   wb_adr_i,
    input  logic [rxlink_map_pkg::SEL_BITS-1:0]   wb_sel_i,
    input  logic [rxlink_map_pkg::DAT_BITS-1:0]   wb_dat_i,
    output logic [rxlink_map_pkg::DAT_BITS-1:0]   wb_dat_o,
    output logic                                  wb_ack_o,
    input  logic                                  rxclk_i,
    input  logic                                  rxclk_ok_i,
    output logic                                  ps_en_o,
    input  logic                                  ps_done_i,
    input  logic                                  mmcm_locked_i,
    output logic                                  mmcm_rst_o,
    output logic                                  cin_rst_o,
    output logic                                  en_vtc_o,
    output logic                                  delay_load_o,
    output logic                                  delay_rd_o,
    output logic [1:0]                            delay_sel_o,
    output logic [rxlink_map_pkg::DELAY_BITS-1:0] delay_cntvaluein_o,
    input  logic [rxlink_map_pkg::DELAY_BITS-1:0] delay_cntvalueout_i,
    input  logic                                  idelayctrl_rdy_i,
    output logic                                  idelayctrl_rst_o,
    input  logic                                  data_active_i,
    output logic                                  train_en_o
);
    import rxlink_map_pkg::*;
    import rxlink_ctrl_pkg::*;

    logic                ctrl_wr;
    logic [DAT_BITS-1:0] wr_data;
    logic [SEL_BITS-1:0] wr_sel;
    ctrl_word_u          ctrl_word;
    logic [PS_BITS-1:0]  ps_target;
    logic                ps_incomplete;

    delay_req_if dly_if ();

    wb_access_ctrl u_access (
        .wb_clk_i    (wb_clk_i),
        .wb_rst_i    (wb_rst_i),
        .wb_cyc_i    (wb_cyc_i),
        .wb_stb_i    (wb_stb_i),
        .wb_we_i     (wb_we_i),
        .wb_adr_i    (wb_adr_i),
        .wb_sel_i    (wb_sel_i),
        .wb_dat_i    (wb_dat_i),
        .rxclk_ok_i  (rxclk_ok_i),
        .ctrl_word_i (ctrl_word),
        .wb_dat_o    (wb_dat_o),
        .wb_ack_o    (wb_ack_o),
        .ctrl_wr_o   (ctrl_wr),
        .wr_data_o   (wr_data),
        .wr_sel_o    (wr_sel),
        .dly         (dly_if.fsm)
    );

    ctrl_reg_file u_regs (
        .wb_clk_i         (wb_clk_i),
        .wb_rst_i         (wb_rst_i),
        .ctrl_wr_i        (ctrl_wr),
        .wr_data_i        (wr_data),
        .wr_sel_i         (wr_sel),
        .ps_incomplete_i  (ps_incomplete),
        .idelayctrl_rdy_i (idelayctrl_rdy_i),
        .mmcm_locked_i    (mmcm_locked_i),
        .data_active_i    (data_active_i),
        .ctrl_word_o      (ctrl_word),
        .ps_target_o      (ps_target),
        .cin_rst_o        (cin_rst_o),
        .en_vtc_o         (en_vtc_o),
        .idelayctrl_rst_o (idelayctrl_rst_o),
        .mmcm_rst_o       (mmcm_rst_o),
        .train_en_o       (train_en_o)
    );

    phase_shift_stepper u_ps (
        .wb_clk_i        (wb_clk_i),
        .wb_rst_i        (wb_rst_i),
        .ps_target_i     (ps_target),
        .ps_done_i       (ps_done_i),
        .ps_en_o         (ps_en_o),
        .ps_incomplete_o (ps_incomplete)
    );

    rxclk_delay_bridge u_bridge (
        .wb_clk_i            (wb_clk_i),
        .wb_rst_i            (wb_rst_i),
        .rxclk_i             (rxclk_i),
        .delay_cntvalueout_i (delay_cntvalueout_i),
        .dly                 (dly_if.bridge),
        .delay_load_o        (delay_load_o),
        .delay_rd_o          (delay_rd_o),
        .delay_sel_o         (delay_sel_o),
        .delay_cntvaluein_o  (delay_cntvaluein_o)
    );

endmodule

// File: sim/tb_checker.sv
module tb_checker (
    input  logic        clk_i,
    input  logic        wb_ack_i,
    input  logic [31:0] wb_dat_i,
    input  logic        ps_en_i,
    input  logic        cin_rst_i,
    input  logic        en_vtc_i,
    input  logic        idelayctrl_rst_i,
    input  logic        mmcm_rst_i,
    input  logic        train_en_i,
    input  logic        rd_check_i,
    input  logic [31:0] exp_dat_i,
    input  logic [4:0]  exp_pins_i,
    input  int          exp_ps_i,
    input  logic        test_end_i,
    input  int          test_id_i,
    input  logic        all_done_i,
    output int          err_count_o
);

    int         ps_seen = 0;
    int         reads_seen = 0;
    int         test_errs = 0;
    int         tests = 0;
    int         total_errs = 0;
    logic [4:0] pins;

    assign pins        = {cin_rst_i, en_vtc_i, idelayctrl_rst_i, mmcm_rst_i, train_en_i};
    assign err_count_o = total_errs;

    always @(posedge clk_i) begin
        if (ps_en_i) begin
            ps_seen = ps_seen + 1;
        end
        // read data is registered, stable through the ack cycle
        if (wb_ack_i && rd_check_i) begin
            reads_seen = reads_seen + 1;
            if (wb_dat_i !== exp_dat_i) begin
                $display("ERR %0t: test %0d read %h, expected %h",
                         $time, test_id_i, wb_dat_i, exp_dat_i);
                test_errs = test_errs + 1;
            end
        end
        if (test_end_i) begin
            if (pins !== exp_pins_i) begin
                $display("ERR %0t: test %0d outputs %b, expected %b",
                         $time, test_id_i, pins, exp_pins_i);
                test_errs = test_errs + 1;
            end
            if (ps_seen != exp_ps_i) begin
                $display("ERR %0t: test %0d saw %0d phase steps, expected %0d",
                         $time, test_id_i, ps_seen, exp_ps_i);
                test_errs = test_errs + 1;
            end
            if (rd_check_i && reads_seen == 0) begin
                $display("test %0d finished without any read data to check", test_id_i);
                test_errs = test_errs + 1;
            end
            $display("test %0d %s", test_id_i, (test_errs == 0) ? "ok" : "FAILED");
            total_errs = total_errs + test_errs;
            tests      = tests + 1;
            test_errs  = 0;
            ps_seen    = 0;
            reads_seen = 0;
        end
        if (all_done_i) begin
            $display("%0d tests run, %0d errors", tests, total_errs);
        end
    end

endmodule

// File: sim/tb_rxlink_reg_core.sv
module tb_rxlink_reg_core;
    import rxlink_map_pkg::*;
    import rxlink_ctrl_pkg::*;

    localparam int MAX_ROWS   = 32;
    localparam int ACK_LIMIT  = 2000;
    // a full wrap is 671 steps of about 4 cycles each
    localparam int POLL_LIMIT = 2000;

    logic                  wb_clk_i, wb_rst_i, wb_cyc_i, wb_stb_i, wb_we_i;
    logic [ADR_BITS-1:0]   wb_adr_i;
    logic [SEL_BITS-1:0]   wb_sel_i;
    logic [DAT_BITS-1:0]   wb_dat_i, wb_dat_o;
    logic                  wb_ack_o, rxclk_i, rxclk_ok_i, ps_en_o, ps_done_i;
    logic                  mmcm_locked_i, mmcm_rst_o, cin_rst_o, en_vtc_o;
    logic                  delay_load_o, delay_rd_o, idelayctrl_rdy_i, idelayctrl_rst_o;
    logic                  data_active_i, train_en_o;
    logic [1:0]            delay_sel_o;
    logic [DELAY_BITS-1:0] delay_cntvaluein_o, delay_cntvalueout_i;

    // checker control
    logic                rd_check, test_end, all_done;
    logic [DAT_BITS-1:0] exp_dat;
    logic [4:0]          exp_pins;
    int                  exp_ps, test_id, err_count;

    // stimulus table
    logic                row_we [MAX_ROWS];
    logic [ADR_BITS-1:0] row_adr [MAX_ROWS];
    logic [SEL_BITS-1:0] row_sel [MAX_ROWS];
    logic [DAT_BITS-1:0] row_dat [MAX_ROWS];
    logic [DAT_BITS-1:0] row_exp [MAX_ROWS];
    logic [2:0]          row_stat [MAX_ROWS];
    logic                row_rx_ok [MAX_ROWS];
    logic [4:0]          row_pins [MAX_ROWS];
    int                  row_ps [MAX_ROWS];
    int                  n_rows;

    logic [2:0]            done_pipe = 3'b000;
    logic [DELAY_BITS-1:0] tap_mem [4];
    logic [DELAY_BITS-1:0] tap_rd_q = '0;
    logic [DELAY_BITS-1:0] tap_val [4];
    integer                seed;

    rxlink_reg_core UUT (.*);

    tb_checker u_checker (
        .clk_i            (wb_clk_i),
        .wb_ack_i         (wb_ack_o),
        .wb_dat_i         (wb_dat_o),
        .ps_en_i          (ps_en_o),
        .cin_rst_i        (cin_rst_o),
        .en_vtc_i         (en_vtc_o),
        .idelayctrl_rst_i (idelayctrl_rst_o),
        .mmcm_rst_i       (mmcm_rst_o),
        .train_en_i       (train_en_o),
        .rd_check_i       (rd_check),
        .exp_dat_i        (exp_dat),
        .exp_pins_i       (exp_pins),
        .exp_ps_i         (exp_ps),
        .test_end_i       (test_end),
        .test_id_i        (test_id),
        .all_done_i       (all_done),
        .err_count_o      (err_count)
    );

    initial begin
        wb_clk_i = 1'b0;
        forever #4 wb_clk_i = ~wb_clk_i;
    end

    initial begin
        rxclk_i = 1'b0;
        forever #3 rxclk_i = ~rxclk_i;
    end

    ////////////////////
    // device models
    ////////////////////
    // MMCM answers each step 3 cycles later
    always @(negedge wb_clk_i) begin
        if (wb_rst_i) begin
            done_pipe <= 3'b000;
        end else begin
            done_pipe <= {done_pipe[1:0], ps_en_o};
        end
    end
    assign ps_done_i = done_pipe[2];

    // taps load on the load strobe and show their count on the read strobe
    always @(posedge rxclk_i) begin
        if (wb_rst_i) begin
            for (int i = 0; i < 4; i++) begin
                tap_mem[i] <= '0;
            end
            tap_rd_q <= '0;
        end else begin
            if (delay_load_o) begin
                tap_mem[delay_sel_o] <= delay_cntvaluein_o;
            end
            if (delay_rd_o) begin
                tap_rd_q <= tap_mem[delay_sel_o];
            end
        end
    end
    assign delay_cntvalueout_i = tap_rd_q;

    function automatic int wrap_steps(input int target, input int cur);
        return (target - cur + PS_STEPS) % PS_STEPS;
    endfunction

    task automatic add_row(input logic we, input logic [ADR_BITS-1:0] adr,
                           input logic [SEL_BITS-1:0] sel, input logic [DAT_BITS-1:0] dat,
                           input logic [DAT_BITS-1:0] exp, input logic [2:0] stat,
                           input logic rx_ok, input logic [4:0] pins, input int ps);
        row_we[n_rows]    = we;
        row_adr[n_rows]   = adr;
        row_sel[n_rows]   = sel;
        row_dat[n_rows]   = dat;
        row_exp[n_rows]   = exp;
        row_stat[n_rows]  = stat;
        row_rx_ok[n_rows] = rx_ok;
        row_pins[n_rows]  = pins;
        row_ps[n_rows]    = ps;
        n_rows++;
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failures found");
        $finish;
    endtask

    task automatic bus_op(input logic we, input logic [ADR_BITS-1:0] adr,
                          input logic [SEL_BITS-1:0] sel, input logic [DAT_BITS-1:0] dat,
                          output logic [DAT_BITS-1:0] rd);
        int n;
        n = 0;
        @(negedge wb_clk_i);
        {wb_cyc_i, wb_stb_i, wb_we_i} = {2'b11, we};
        wb_adr_i = adr;
        wb_sel_i = sel;
        wb_dat_i = dat;
        do begin
            @(negedge wb_clk_i);
            n++;
            if (n > ACK_LIMIT) begin
                abort_run($sformatf("no bus ack came back for address %h", adr));
            end
        end while (!wb_ack_o);
        rd = wb_dat_o;
        {wb_cyc_i, wb_stb_i, wb_we_i} = 3'b000;
    endtask

    // poll bit 31 until the stepper reaches the target
    task automatic wait_phase_idle();
        logic [DAT_BITS-1:0] rd;
        int n;
        n = 0;
        do begin
            bus_op(1'b0, CONTROL_REG, 4'hF, '0, rd);
            n++;
            if (n > POLL_LIMIT) begin
                abort_run("phase stepping never finished");
            end
        end while (rd[31]);
    endtask

    task automatic run_row(input int i);
        logic [DAT_BITS-1:0] rd;
        @(negedge wb_clk_i);
        {data_active_i, mmcm_locked_i, idelayctrl_rdy_i} = row_stat[i];
        rxclk_ok_i = row_rx_ok[i];
        test_id    = i;
        rd_check   = !row_we[i];
        exp_dat    = row_exp[i];
        exp_pins   = row_pins[i];
        exp_ps     = row_ps[i];
        // let the status synchronizers settle
        repeat (5) @(negedge wb_clk_i);
        bus_op(row_we[i], row_adr[i], row_sel[i], row_dat[i], rd);
        if (row_we[i] && row_adr[i] == CONTROL_REG) begin
            wait_phase_idle();
        end
        @(negedge wb_clk_i);
        test_end = 1'b1;
        @(negedge wb_clk_i);
        test_end = 1'b0;
        rd_check = 1'b0;
    endtask

    initial begin
        integer rnd;
        seed = 67403;
        {wb_cyc_i, wb_stb_i, wb_we_i} = 3'b000;
        wb_adr_i = '0;
        wb_sel_i = '0;
        wb_dat_i = '0;
        {data_active_i, mmcm_locked_i, idelayctrl_rdy_i} = 3'b000;
        rxclk_ok_i = 1'b1;
        {rd_check, test_end, all_done} = 3'b000;
        exp_dat  = '0;
        exp_pins = '0;
        {exp_ps, test_id, n_rows} = {32'd0, 32'd0, 32'd0};
        for (int i = 0; i < 4; i++) begin
            rnd = $random(seed);
            tap_val[i] = rnd[DELAY_BITS-1:0];
        end

        // pins are {cin_rst, en_vtc, idelayctrl_rst, mmcm_rst, train_en}
        add_row(0, 11'h000, 4'hF, 0, 32'h0, 3'b000, 1, 5'b01000, 0);
        add_row(1, 11'h000, 4'h1, 32'hFFFF_0057, 0, 3'b000, 1, 5'b10111, 0);
        add_row(0, 11'h000, 4'hF, 0, 32'h57, 3'b000, 1, 5'b10111, 0);
        add_row(1, 11'h000, 4'hE, 32'h0, 0, 3'b000, 1, 5'b10111, 0);
        add_row(0, 11'h000, 4'hF, 0, 32'h57, 3'b000, 1, 5'b10111, 0);
        add_row(1, 11'h000, 4'h1, 32'h02, 0, 3'b000, 1, 5'b00000, 0);
        add_row(0, 11'h000, 4'hF, 0, 32'h02, 3'b000, 1, 5'b00000, 0);
        add_row(0, 11'h000, 4'hF, 0, 32'hAA, 3'b111, 1, 5'b00000, 0);

        ////////////////////
        // phase stepping
        ////////////////////
        add_row(1, 11'h000, 4'hC, 100 << 16, 0, 3'b000, 1, 5'b0, wrap_steps(100, 0));
        add_row(0, 11'h000, 4'hF, 0, (100 << 16) | 2, 3'b000, 1, 5'b0, 0);
        add_row(1, 11'h000, 4'hC, 5 << 16, 0, 3'b000, 1, 5'b0, wrap_steps(5, 100));
        add_row(0, 11'h000, 4'hF, 0, (5 << 16) | 2, 3'b000, 1, 5'b0, 0);
        add_row(1, 11'h000, 4'h4, 300 << 16, 0, 3'b000, 1, 5'b0, 0);
        add_row(0, 11'h000, 4'hF, 0, (5 << 16) | 2, 3'b000, 1, 5'b0, 0);

        ////////////////////
        // delay taps
        ////////////////////
        for (int t = 0; t < 4; t++) begin
            add_row(1, RXCLK_DOMAIN | 11'(4 * t), 4'h3, 32'(tap_val[t]), 0, 3'b000, 1, 5'b0, 0);
        end
        for (int t = 0; t < 4; t++) begin
            add_row(0, RXCLK_DOMAIN | 11'(4 * t), 4'hF, 0, 32'(tap_val[t]), 3'b000, 1, 5'b0, 0);
        end
        add_row(1, 11'h084, 4'h1, 32'(~tap_val[1]), 0, 3'b000, 1, 5'b0, 0);
        add_row(0, 11'h084, 4'hF, 0, 32'(tap_val[1]), 3'b000, 1, 5'b0, 0);
        add_row(0, 11'h088, 4'hF, 0, 32'hFFFF_FFFF, 3'b000, 0, 5'b0, 0);

        // former aclk window
        add_row(0, 11'h040, 4'hF, 0, (5 << 16) | 2, 3'b000, 1, 5'b0, 0);
        add_row(1, 11'h040, 4'hF, 32'h0000_0051, 0, 3'b000, 1, 5'b0, 0);
        add_row(0, 11'h000, 4'hF, 0, (5 << 16) | 2, 3'b000, 1, 5'b0, 0);

        wb_rst_i = 1'b1;
        repeat (2) @(posedge wb_clk_i);
        @(negedge wb_clk_i);
        wb_rst_i = 1'b0;

        for (int i = 0; i < n_rows; i++) begin
            run_row(i);
        end

        @(negedge wb_clk_i);
        all_done = 1'b1;
        @(negedge wb_clk_i);
        if (err_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: vlog.f
hdl/rxlink_map_pkg.sv
hdl/rxlink_ctrl_pkg.sv
hdl/delay_req_if.sv
hdl/flag_sync.sv
hdl/ctrl_reg_file.sv
hdl/phase_shift_stepper.sv
hdl/rxclk_delay_bridge.sv
hdl/wb_access_ctrl.sv
hdl/rxlink_reg_core.sv
sim/tb_checker.sv
sim/tb_rxlink_reg_core.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator.
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f vlog.f \
    --top-module tb_rxlink_reg_core -Mdir obj_dir -o tb_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test failures found" "$LOG"; then
    exit 1
fi
exit 0
